//--- source/memPkg.sv
`default_nettype none

package memPkg;

    // full byte address of either port
    localparam int AddrWidth = 11;
    localparam int DataWidth = 8;

    // word address inside one 128 x 8 sub-array
    localparam int WordAddrWidth = 7;
    localparam int SubArrayDepth = 1 << WordAddrWidth;

    // 4 banks of 4 sub-arrays, numbered bank * 4 + sub-array
    localparam int NumSubArrays = 16;

    // upper address bits that pick the sub-array (bank and sub-array fields)
    localparam int SubSelWidth = AddrWidth - WordAddrWidth;

    // one-entry held-write buffer
    typedef enum logic {
        WbEmpty = 1'b0,
        WbHeld  = 1'b1
    } wbState_e;

endpackage

`default_nettype wire

//--- source/memCmdIf.sv
`timescale 1ns/100ps
`default_nettype none

interface memCmdIf;

    // one bit per sub-array, read select is one-hot or zero
    logic [memPkg::NumSubArrays-1:0]  subRen;
    // at most one bit set per cycle
    logic [memPkg::NumSubArrays-1:0]  subWen;

    // word addresses and write byte are shared by all sub-arrays
    logic [memPkg::WordAddrWidth-1:0] rdWordAddr;
    logic [memPkg::WordAddrWidth-1:0] wrWordAddr;
    logic [memPkg::DataWidth-1:0]     wrByte;

    modport ctrl (
        output subRen,
        output subWen,
        output rdWordAddr,
        output wrWordAddr,
        output wrByte
    );

    modport array (
        input subRen,
        input subWen,
        input rdWordAddr,
        input wrWordAddr,
        input wrByte
    );

endinterface

`default_nettype wire

//--- source/subArray.sv
`timescale 1ns/100ps
`default_nettype none

module subArray #(
    parameter int SubIndex = 0
) (
    input wire                            clk,
    memCmdIf.array                        cmd,
    output logic [memPkg::DataWidth-1:0]  rdByte
);

    logic [memPkg::DataWidth-1:0] mem [0:memPkg::SubArrayDepth-1];

    logic ren;
    logic wen;

    // this instance's own bit of the shared command vectors
    assign ren = cmd.subRen[SubIndex];
    assign wen = cmd.subWen[SubIndex];

    // a read of this sub-array always wins over a write
    always_ff @(posedge clk) begin
        if (wen && !ren) begin
            mem[cmd.wrWordAddr] <= cmd.wrByte;
        end
    end

    // idle sub-arrays drive zero so the outputs can simply be OR-ed
    always_ff @(posedge clk) begin
        if (ren) begin
            rdByte <= mem[cmd.rdWordAddr];
        end else begin
            rdByte <= '0;
        end
    end

endmodule

`default_nettype wire

//--- source/bankCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module bankCtrl (
    input wire                              clk,
    input wire                              rstN,
    input wire                              rdEn,
    input wire  [memPkg::AddrWidth-1:0]     rdAddr,
    input wire                              wrEn,
    input wire  [memPkg::AddrWidth-1:0]     wrAddr,
    input wire  [memPkg::DataWidth-1:0]     wrData,
    memCmdIf.ctrl                           cmd,
    output logic                            wrBusy
);

    // one-hot sub-array select from bank and sub-array address bits
    function automatic logic [memPkg::NumSubArrays-1:0] subSelect(
        input logic [memPkg::AddrWidth-1:0] addr
    );
        logic [memPkg::SubSelWidth-1:0] idx;
        idx = addr[memPkg::AddrWidth-1 -: memPkg::SubSelWidth];
        return memPkg::NumSubArrays'(1) << idx;
    endfunction

    memPkg::wbState_e wbState;
    memPkg::wbState_e nextState;

    logic [memPkg::AddrWidth-1:0]    heldAddr;
    logic [memPkg::DataWidth-1:0]    heldData;

    logic [memPkg::NumSubArrays-1:0] rdSel;
    logic [memPkg::NumSubArrays-1:0] wrSel;
    logic [memPkg::NumSubArrays-1:0] heldSel;
    logic                            newConflict;
    logic                            heldConflict;

    logic                            captureWr;
    logic [memPkg::NumSubArrays-1:0] wenOut;
    logic [memPkg::WordAddrWidth-1:0] wrWordOut;
    logic [memPkg::DataWidth-1:0]    wrByteOut;

    assign rdSel   = rdEn ? subSelect(rdAddr) : '0;
    assign wrSel   = wrEn ? subSelect(wrAddr) : '0;
    assign heldSel = subSelect(heldAddr);

    // a read into the same sub-array blocks the write this cycle
    assign newConflict  = |(rdSel & wrSel);
    assign heldConflict = |(rdSel & heldSel);

    always_comb begin
        nextState = wbState;
        captureWr = 1'b0;
        wenOut    = '0;
        wrWordOut = wrAddr[memPkg::WordAddrWidth-1:0];
        wrByteOut = wrData;
        case (wbState)
            memPkg::WbEmpty: begin
                if (wrEn) begin
                    if (newConflict) begin
                        captureWr = 1'b1;
                        nextState = memPkg::WbHeld;
                    end else begin
                        wenOut = wrSel;
                    end
                end
            end
            memPkg::WbHeld: begin
                // held write goes first, any new wrEn is dropped meanwhile
                wrWordOut = heldAddr[memPkg::WordAddrWidth-1:0];
                wrByteOut = heldData;
                if (!heldConflict) begin
                    wenOut    = heldSel;
                    nextState = memPkg::WbEmpty;
                end
            end
            default: begin
                nextState = memPkg::WbEmpty;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbState <= memPkg::WbEmpty;
        end else begin
            wbState <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (captureWr) begin
            heldAddr <= wrAddr;
            heldData <= wrData;
        end
    end

    assign cmd.subRen     = rdSel;
    assign cmd.rdWordAddr = rdAddr[memPkg::WordAddrWidth-1:0];
    assign cmd.subWen     = wenOut;
    assign cmd.wrWordAddr = wrWordOut;
    assign cmd.wrByte     = wrByteOut;

    assign wrBusy = (wbState == memPkg::WbHeld);

endmodule

`default_nettype wire

//--- source/readMerge.sv
`timescale 1ns/100ps
`default_nettype none

module readMerge (
    input wire                                                  clk,
    input wire                                                  rstN,
    input wire                                                  rdEn,
    input wire [memPkg::NumSubArrays-1:0][memPkg::DataWidth-1:0] subData,
    output logic [memPkg::DataWidth-1:0]                        rdData,
    output logic                                                rdValid
);

    // only the addressed sub-array is non-zero
    always_comb begin
        rdData = '0;
        for (int i = 0; i < memPkg::NumSubArrays; i++) begin
            rdData = rdData | subData[i];
        end
    end

    // same latency as the registered read inside each sub-array
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdEn;
        end
    end

endmodule

`default_nettype wire

//--- source/memTop.sv
`timescale 1ns/100ps
`default_nettype none

module memTop (
    input wire                              clk,
    input wire                              rstN,
    input wire                              rdEn,
    input wire  [memPkg::AddrWidth-1:0]     rdAddr,
    input wire                              wrEn,
    input wire  [memPkg::AddrWidth-1:0]     wrAddr,
    input wire  [memPkg::DataWidth-1:0]     wrData,
    output logic [memPkg::DataWidth-1:0]    rdData,
    output logic                            rdValid,
    output logic                            wrBusy
);

    // per-sub-array read bytes, index is bank * 4 + sub-array
    logic [memPkg::NumSubArrays-1:0][memPkg::DataWidth-1:0] subData;

    memCmdIf cmdIf ();

    bankCtrl i_bankCtrl (
        .clk    (clk),
        .rstN   (rstN),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .cmd    (cmdIf.ctrl),
        .wrBusy (wrBusy)
    );

    for (genvar i = 0; i < memPkg::NumSubArrays; i++) begin : genSub
        subArray #(
            .SubIndex (i)
        ) i_subArray (
            .clk    (clk),
            .cmd    (cmdIf.array),
            .rdByte (subData[i])
        );
    end

    readMerge i_readMerge (
        .clk     (clk),
        .rstN    (rstN),
        .rdEn    (rdEn),
        .subData (subData),
        .rdData  (rdData),
        .rdValid (rdValid)
    );

endmodule

`default_nettype wire

//--- tb/clkGen.sv
`timescale 1ns/100ps
`default_nettype none

module clkGen (
    output logic clk,
    output logic rstN
);

    localparam int HalfPeriod  = 20;
    localparam int ResetCycles = 2;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/memMonitor.sv
`timescale 1ns/100ps
`default_nettype none

module memMonitor (
    input wire                              clk,
    input wire                              checkEn,
    input wire                              expRdValid,
    input wire  [memPkg::DataWidth-1:0]     expRdData,
    input wire                              expWrBusy,
    input wire                              rdValid,
    input wire  [memPkg::DataWidth-1:0]     rdData,
    input wire                              wrBusy,
    output int                              errCount
);

    int errors = 0;

    logic                          pendCheck = 1'b0;
    logic                          pendRdValid;
    logic [memPkg::DataWidth-1:0]  pendRdData;
    logic                          pendWrBusy;

    assign errCount = errors;

    task automatic reportMismatch(
        input string                         name,
        input logic [memPkg::DataWidth-1:0]  expVal,
        input logic [memPkg::DataWidth-1:0]  actVal
    );
        errors = errors + 1;
        $display("ERR %0t %s expected %h actual %h", $time, name, expVal, actVal);
    endtask

    // expected values belong to the inputs sampled at this edge
    always @(posedge clk) begin
        pendCheck   <= checkEn;
        pendRdValid <= expRdValid;
        pendRdData  <= expRdData;
        pendWrBusy  <= expWrBusy;
    end

    // outputs are all registered, so they are settled by the falling edge
    always @(negedge clk) begin
        if (pendCheck) begin
            if (rdValid !== pendRdValid) begin
                reportMismatch("rdValid", {7'b0, pendRdValid}, {7'b0, rdValid});
            end
            if (rdData !== pendRdData) begin
                reportMismatch("rdData", pendRdData, rdData);
            end
            if (wrBusy !== pendWrBusy) begin
                reportMismatch("wrBusy", {7'b0, pendWrBusy}, {7'b0, wrBusy});
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/memTop_chk.sv
`timescale 1ns/100ps
`default_nettype none

module memTop_chk (
    input wire                              clk,
    input wire                              rstN,
    input wire                              rdEn,
    input wire                              wrEn,
    input wire                              rdValid,
    input wire  [memPkg::DataWidth-1:0]     rdData,
    input wire                              wrBusy
);

    int validFails = 0;
    int zeroFails = 0;
    int busyFails = 0;
    int failCount;

    assign failCount = validFails + zeroFails + busyFails;

    // valid is the read strobe delayed by one edge
    validFollowsRead: assert property (
        @(posedge clk) disable iff (!rstN)
        $past(rstN) |-> (rdValid == $past(rdEn))
    ) else begin
        validFails = validFails + 1;
        $error("rdValid does not follow rdEn by one cycle");
    end

    idleDataZero: assert property (
        @(posedge clk) disable iff (!rstN)
        !rdValid |-> (rdData == '0)
    ) else begin
        zeroFails = zeroFails + 1;
        $error("rdData is not zero while rdValid is low");
    end

    // host must hold off new writes while one is buffered
    noWriteWhileBusy: assert property (
        @(posedge clk) disable iff (!rstN)
        wrBusy |-> !wrEn
    ) else begin
        busyFails = busyFails + 1;
        $error("wrEn asserted while wrBusy is high");
    end

endmodule

bind memTop memTop_chk chk (
    .clk     (clk),
    .rstN    (rstN),
    .rdEn    (rdEn),
    .wrEn    (wrEn),
    .rdValid (rdValid),
    .rdData  (rdData),
    .wrBusy  (wrBusy)
);

`default_nettype wire

//--- tb/memTb.sv
`timescale 1ns/100ps
`default_nettype none

module memTb;

    localparam int MaxLines = 128;
    localparam int FieldsPerLine = 8;
    localparam int StimWords = MaxLines * FieldsPerLine;
    localparam logic [11:0] EndMark = 12'hFFF;

    logic                          clk;
    logic                          rstN;

    logic                          rdEn;
    logic [memPkg::AddrWidth-1:0]  rdAddr;
    logic                          wrEn;
    logic [memPkg::AddrWidth-1:0]  wrAddr;
    logic [memPkg::DataWidth-1:0]  wrData;
    logic [memPkg::DataWidth-1:0]  rdData;
    logic                          rdValid;
    logic                          wrBusy;

    logic                          checkEn;
    logic                          expRdValid;
    logic [memPkg::DataWidth-1:0]  expRdData;
    logic                          expWrBusy;
    int                            monErrors;

    // eight hex fields per vector, unused entries keep the end mark
    logic [11:0] stim [0:StimWords-1];
    int numLines = 0;
    int cycleLimit = 0;
    int cycles = 0;
    int totalErrors;

    clkGen i_clkGen (
        .clk  (clk),
        .rstN (rstN)
    );

    memTop i_memTop (
        .clk     (clk),
        .rstN    (rstN),
        .rdEn    (rdEn),
        .rdAddr  (rdAddr),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rdData  (rdData),
        .rdValid (rdValid),
        .wrBusy  (wrBusy)
    );

    memMonitor i_memMonitor (
        .clk        (clk),
        .checkEn    (checkEn),
        .expRdValid (expRdValid),
        .expRdData  (expRdData),
        .expWrBusy  (expWrBusy),
        .rdValid    (rdValid),
        .rdData     (rdData),
        .wrBusy     (wrBusy),
        .errCount   (monErrors)
    );

    task automatic applyVector(input int idx);
        int base;
        base = idx * FieldsPerLine;
        rdEn       = stim[base][0];
        rdAddr     = stim[base + 1][memPkg::AddrWidth-1:0];
        wrEn       = stim[base + 2][0];
        wrAddr     = stim[base + 3][memPkg::AddrWidth-1:0];
        wrData     = stim[base + 4][memPkg::DataWidth-1:0];
        expRdValid = stim[base + 5][0];
        expRdData  = stim[base + 6][memPkg::DataWidth-1:0];
        expWrBusy  = stim[base + 7][0];
        checkEn    = 1'b1;
    endtask

    task automatic driveIdle();
        rdEn    = 1'b0;
        rdAddr  = '0;
        wrEn    = 1'b0;
        wrAddr  = '0;
        wrData  = '0;
        checkEn = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout: stimulus did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        driveIdle();
        expRdValid = 1'b0;
        expRdData  = '0;
        expWrBusy  = 1'b0;
        for (int i = 0; i < StimWords; i++) begin
            stim[i] = EndMark;
        end
        $readmemh("tb/mem_stim.txt", stim);
        while (numLines < MaxLines && stim[numLines * FieldsPerLine] != EndMark) begin
            numLines = numLines + 1;
        end
        cycleLimit = numLines + 20;
        if (numLines == 0) begin
            $display("stim file tb/mem_stim.txt is missing or holds no vectors");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            wait (rstN === 1'b1);
            for (int k = 0; k < numLines; k++) begin
                @(negedge clk);
                applyVector(k);
            end
            @(negedge clk);
            driveIdle();
            // let the assertions of the last sampled edge settle
            @(posedge clk);
            @(negedge clk);
            totalErrors = monErrors + i_memTop.chk.failCount;
            $display("summary: %0d vectors, %0d mismatches, %0d assertion failures",
                     numLines, monErrors, i_memTop.chk.failCount);
            if (totalErrors == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/mem_stim.txt
// rdEn rdAddr wrEn wrAddr wrData | expRdValid expRdData expWrBusy
// expected fields are the outputs after the edge that samples the line
0 000 0 000 00 0 00 0
0 000 1 003 0F 0 00 0
0 000 1 08A 1E 0 00 0
0 000 1 111 2D 0 00 0
0 000 1 198 3C 0 00 0
0 000 1 21F 4B 0 00 0
0 000 1 2A6 5A 0 00 0
0 000 1 32D 69 0 00 0
0 000 1 3B4 78 0 00 0
0 000 1 43B 87 0 00 0
0 000 1 4C2 96 0 00 0
0 000 1 549 A5 0 00 0
0 000 1 5D0 B4 0 00 0
0 000 1 657 C3 0 00 0
0 000 1 6DE D2 0 00 0
0 000 1 765 E1 0 00 0
0 000 1 7EC F0 0 00 0
0 000 0 000 00 0 00 0
1 003 1 440 11 1 0F 0
1 08A 1 4C0 22 1 1E 0
1 111 1 540 33 1 2D 0
1 198 1 5C0 44 1 3C 0
1 21F 1 640 55 1 4B 0
1 2A6 1 6C0 66 1 5A 0
1 32D 1 740 77 1 69 0
1 3B4 1 7C0 88 1 78 0
1 43B 0 000 00 1 87 0
1 4C2 0 000 00 1 96 0
1 549 0 000 00 1 A5 0
1 5D0 0 000 00 1 B4 0
1 657 0 000 00 1 C3 0
1 6DE 0 000 00 1 D2 0
1 765 0 000 00 1 E1 0
1 7EC 0 000 00 1 F0 0
0 000 0 000 00 0 00 0
1 440 0 000 00 1 11 0
1 4C0 0 000 00 1 22 0
1 540 0 000 00 1 33 0
1 5C0 0 000 00 1 44 0
0 000 0 000 00 0 00 0
1 640 0 000 00 1 55 0
1 6C0 0 000 00 1 66 0
1 740 0 000 00 1 77 0
1 7C0 0 000 00 1 88 0
1 003 1 003 5C 1 0F 1
0 000 0 000 00 0 00 0
1 003 0 000 00 1 5C 0
1 08A 1 0A0 E7 1 1E 1
1 08A 0 000 00 1 1E 1
1 08A 0 000 00 1 1E 1
1 003 0 000 00 1 5C 0
1 0A0 0 000 00 1 E7 0
1 198 1 198 3A 1 3C 1
1 198 0 000 00 1 3C 1
1 21F 0 000 00 1 4B 0
1 198 0 000 00 1 3A 0
1 111 1 112 9D 1 2D 1
1 43B 0 000 00 1 87 0
1 112 1 6C0 42 1 9D 0
1 6C0 0 000 00 1 42 0
0 000 0 000 00 0 00 0
0 000 0 000 00 0 00 0

//--- files.f
source/memPkg.sv
source/memCmdIf.sv
source/subArray.sv
source/bankCtrl.sv
source/readMerge.sv
source/memTop.sv
tb/clkGen.sv
tb/memMonitor.sv
tb/memTop_chk.sv
tb/memTb.sv

//--- Makefile
TOP := memTb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --top-module $(TOP) -f files.f -o $(TOP)

# the simulation keeps going past assertion errors so the testbench prints its verdict
run: compile
	-./obj_dir/$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
